// File: logic/debug_pkg.sv
package debug_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int BYTE_W         = 8;       // one uart byte
    localparam int WORD_W         = 32;      // one instruction
    localparam int ADDR_W         = 11;      // instruction memory depth 2k
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_CNT_W     = $clog2(BYTES_PER_WORD);
    localparam int OPCODE_LSB     = 26;      // opcode sits in the top six bits

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam logic [WORD_W-OPCODE_LSB-1:0] HALT_OPCODE = '1;

    // host command bytes
    localparam byte_t CMD_START      = 8'd1;
    localparam byte_t CMD_CONTINUOUS = 8'd2;
    localparam byte_t CMD_STEP_MODE  = 8'd3;
    localparam byte_t CMD_REPROGRAM  = 8'd5;
    localparam byte_t CMD_STEP       = 8'd6;

    //////////////////////////////////////////////////
    // shared structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;                        // high for one cycle per byte
        byte_t data;
    } rx_byte_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } imem_write_t;

    typedef struct packed {
        logic run_en;                        // cpu advances while high
        logic debug_mode;                    // cpu held off, memory being loaded
    } cpu_ctrl_t;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        PROGRAMMING = 3'd1,
        WAITING     = 3'd2,
        STEP_MODE   = 3'd3,
        CONTINUOUS  = 3'd4,
        SENDING     = 3'd5
    } dbg_state_t;

endpackage

// File: logic/rx_byte_capture.sv
`timescale 1ns/1ps

module rx_byte_capture
    import debug_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     rx_done_tick,
    input  byte_t    rx_data,
    output rx_byte_t rx_byte
);

    logic tick_q;                            // tick as seen last cycle

    // the uart holds its done tick for several cycles, so only the
    // rising edge counts as a new byte
    always_ff @(posedge clk)
    begin
        tick_q       <= rx_done_tick;
        rx_byte.data <= rx_data;             // stable while tick is high
        if (reset)
        begin
            tick_q        <= 1'b0;
            rx_byte.valid <= 1'b0;
        end
        else
        begin
            rx_byte.valid <= rx_done_tick && !tick_q;
        end
    end

endmodule

// File: logic/instr_assembler.sv
`timescale 1ns/1ps

module instr_assembler
    import debug_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        program_mode,
    input  rx_byte_t    rx_byte,
    output imem_write_t imem,
    output logic        program_done
);

    logic [BYTE_CNT_W-1:0] byte_cnt;         // bytes of the current word so far
    word_t                 word_sr;
    addr_t                 wr_addr;
    logic                  wr_en;
    logic                  last_byte;

    assign last_byte = (byte_cnt == BYTE_CNT_W'(BYTES_PER_WORD - 1));

    //////////////////////////////////////////////////
    // word assembly, lsb first
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (program_mode && rx_byte.valid)
        begin
            // new byte enters at the top and walks down
            word_sr <= {rx_byte.data, word_sr[WORD_W-1:BYTE_W]};
        end
    end

    // counters restart whenever programming is not active
    always_ff @(posedge clk)
    begin
        if (reset || !program_mode)
        begin
            byte_cnt <= '0;
            wr_addr  <= '0;
            wr_en    <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;
            if (rx_byte.valid)
            begin
                if (last_byte)
                begin
                    byte_cnt <= '0;
                    wr_en    <= 1'b1;        // full word ready next cycle
                end
                else
                begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            if (wr_en)
                wr_addr <= wr_addr + 1'b1;   // step after each write
        end
    end

    // word_sr holds still during the write, next byte is at least two cycles off
    assign imem = '{en: wr_en, addr: wr_addr, data: word_sr};

    assign program_done = wr_en && (word_sr[WORD_W-1:OPCODE_LSB] == HALT_OPCODE);

endmodule

// File: logic/debug_controller.sv
`timescale 1ns/1ps

module debug_controller
    import debug_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  rx_byte_t  rx_byte,
    input  logic      program_done,
    input  logic      halt,
    input  logic      reply_done,
    output logic      program_mode,
    output cpu_ctrl_t cpu_ctrl,
    output logic      reply_req
);

    dbg_state_t state;
    dbg_state_t state_next;
    logic       step_run;                    // single enabled cycle in step mode
    logic       from_step;                   // where to go back after a reply

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (rx_byte.valid && rx_byte.data == CMD_START)
                    state_next = PROGRAMMING;
            end
            PROGRAMMING:
            begin
                if (program_done)            // halt word just written
                    state_next = WAITING;
            end
            WAITING:
            begin
                if (rx_byte.valid)
                begin
                    case (rx_byte.data)
                        CMD_CONTINUOUS: state_next = CONTINUOUS;
                        CMD_STEP_MODE:  state_next = STEP_MODE;
                        default:        state_next = IDLE;   // reprogram or unknown byte
                    endcase
                end
            end
            STEP_MODE:
            begin
                if (rx_byte.valid && rx_byte.data == CMD_STEP)
                    state_next = SENDING;
                else if (rx_byte.valid && rx_byte.data == CMD_REPROGRAM)
                    state_next = IDLE;
            end
            CONTINUOUS:
            begin
                if (halt)
                    state_next = SENDING;
            end
            SENDING:
            begin
                if (reply_done)
                    state_next = from_step ? STEP_MODE : WAITING;
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= IDLE;
            step_run  <= 1'b0;
            reply_req <= 1'b0;
            from_step <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            step_run  <= (state == STEP_MODE) && (state_next == SENDING);
            // step reply waits for the run cycle so status is up to date
            reply_req <= ((state == CONTINUOUS) && halt) || step_run;
            if (state == STEP_MODE)
                from_step <= 1'b1;
            else if (state == CONTINUOUS)
                from_step <= 1'b0;
        end
    end

    assign program_mode        = (state == PROGRAMMING);
    assign cpu_ctrl.debug_mode = program_mode;
    assign cpu_ctrl.run_en     = (state == CONTINUOUS) || step_run;

endmodule

// File: logic/reply_sender.sv
`timescale 1ns/1ps

module reply_sender
    import debug_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  reply_req,
    input  byte_t cpu_status,
    input  logic  tx_done_tick,
    output logic  tx_start,
    output byte_t tx_data,
    output logic  reply_done
);

    logic done_q;                            // tx tick delayed one cycle
    logic done_rise;

    assign done_rise = tx_done_tick && !done_q;

    always_ff @(posedge clk)
    begin
        if (reply_req)
            tx_data <= cpu_status;           // held for the whole transfer
    end

    //////////////////////////////////////////////////
    // transmit handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done_q     <= 1'b0;
            tx_start   <= 1'b0;
            reply_done <= 1'b0;
        end
        else
        begin
            done_q     <= tx_done_tick;
            reply_done <= 1'b0;
            if (reply_req)
            begin
                tx_start <= 1'b1;
            end
            else if (tx_start && done_rise)
            begin
                tx_start   <= 1'b0;          // uart has the byte
                reply_done <= 1'b1;
            end
        end
    end

endmodule

// File: logic/debug_unit.sv
`timescale 1ns/1ps

module debug_unit
    import debug_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        rx_done_tick,
    input  byte_t       rx_data,
    input  logic        tx_done_tick,
    input  logic        halt,                // cpu reached its halt word
    input  byte_t       cpu_status,
    output logic        tx_start,
    output byte_t       tx_data,
    output imem_write_t imem,
    output cpu_ctrl_t   cpu_ctrl
);

    rx_byte_t rx_byte;
    logic     program_mode;
    logic     program_done;
    logic     reply_req;
    logic     reply_done;

    rx_byte_capture i_rx_byte_capture (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data      (rx_data),
        .rx_byte      (rx_byte)
    );

    instr_assembler i_instr_assembler (
        .clk          (clk),
        .reset        (reset),
        .program_mode (program_mode),
        .rx_byte      (rx_byte),
        .imem         (imem),
        .program_done (program_done)
    );

    debug_controller i_debug_controller (
        .clk          (clk),
        .reset        (reset),
        .rx_byte      (rx_byte),
        .program_done (program_done),
        .halt         (halt),
        .reply_done   (reply_done),
        .program_mode (program_mode),
        .cpu_ctrl     (cpu_ctrl),
        .reply_req    (reply_req)
    );

    reply_sender i_reply_sender (
        .clk          (clk),
        .reset        (reset),
        .reply_req    (reply_req),
        .cpu_status   (cpu_status),
        .tx_done_tick (tx_done_tick),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .reply_done   (reply_done)
    );

endmodule

// File: testbench/tb_helpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic int lfsr_take(input int nbits);
    int   value;
    logic fb;
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};       // one step per bit
        value      = (value << 1) | int'(fb);
    end
    return value;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
        errors++;
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
endtask

// random gap, then one tick cycle and one forced low cycle
task automatic send_byte(input byte_t value);
    repeat (lfsr_take(3))
    begin
        @(posedge clk);
        #2;
    end
    rx_data      = value;
    rx_done_tick = 1'b1;
    @(posedge clk);
    #2;
    rx_done_tick = 1'b0;                             // next tick needs a low cycle
    @(posedge clk);
    #2;
endtask

function automatic logic level_of(input int sel);
    case (sel)
        SIG_RUN_EN:   return cpu_ctrl.run_en;
        SIG_TX_START: return tx_start;
        default:      return cpu_ctrl.debug_mode;
    endcase
endfunction

task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (level_of(sel) !== level && cycles < WAIT_LIMIT)
    begin
        @(posedge clk);
        #2;
        cycles++;
    end
    if (level_of(sel) !== level)
    begin
        timeouts++;
        $display("timeout while waiting for %s", what);
    end
endtask

task automatic wait_writes(input int count);
    int cycles;
    cycles = 0;
    while (wr_addr_q.size() < count && cycles < WAIT_LIMIT)
    begin
        @(posedge clk);
        #2;
        cycles++;
    end
    if (wr_addr_q.size() < count)
    begin
        timeouts++;
        $display("timeout while waiting for %0d memory writes", count);
    end
endtask

`endif

// File: testbench/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit
    import debug_pkg::*;
();

    localparam int WAIT_LIMIT     = 100;           // cycles before a wait gives up
    localparam int SIG_RUN_EN     = 0;
    localparam int SIG_TX_START   = 1;
    localparam int SIG_DEBUG_MODE = 2;
    localparam logic [1:0] K_PLAIN = 2'd0;         // no run, no reply expected
    localparam logic [1:0] K_RUN   = 2'd1;         // continuous, tb raises halt
    localparam logic [1:0] K_STEP  = 2'd2;
    localparam logic [1:0] K_LOAD  = 2'd3;         // start plus a program table
    localparam int N_CMDS = 16;

    typedef struct packed {
        logic [1:0] kind;
        byte_t      cmd;
        byte_t      status;                        // cpu_status, also the expected reply
        logic [3:0] run_cycles;
        logic       prog_sel;
    } cmd_entry_t;

    logic        clk;
    logic        reset;
    logic        rx_done_tick;
    logic        tx_done_tick;
    logic        halt;
    byte_t       rx_data;
    byte_t       cpu_status;
    byte_t       tx_data;
    logic        tx_start;
    imem_write_t imem;
    cpu_ctrl_t   cpu_ctrl;

    logic [15:0] lfsr_state;
    int          errors;
    int          timeouts;
    int          run_cnt = 0;
    int          reply_cnt = 0;
    logic        tx_start_q = 1'b0;
    addr_t       wr_addr_q[$];
    word_t       wr_data_q[$];

    word_t prog_words [2][6] = '{
        '{32'h0000_1234, 32'h2041_0003, 32'h8C22_0010, 32'hAC23_0014, 32'hFC00_0000, 32'h0},
        '{32'h1111_2222, 32'h5A5A_A5A5, 32'hFFFF_FFFF, 32'h0, 32'h0, 32'h0}};
    int prog_len [2] = '{5, 3};

    cmd_entry_t cmd_table [N_CMDS] = '{
        '{K_PLAIN, CMD_STEP,       8'h00, 4'd0, 1'b0},   // ignored in idle
        '{K_LOAD,  CMD_START,      8'h00, 4'd0, 1'b0},
        '{K_RUN,   CMD_CONTINUOUS, 8'hA5, 4'd5, 1'b0},
        '{K_RUN,   CMD_CONTINUOUS, 8'h3C, 4'd3, 1'b0},
        '{K_PLAIN, CMD_STEP_MODE,  8'h00, 4'd0, 1'b0},
        '{K_STEP,  CMD_STEP,       8'h11, 4'd1, 1'b0},
        '{K_STEP,  CMD_STEP,       8'h22, 4'd1, 1'b0},
        '{K_PLAIN, CMD_CONTINUOUS, 8'h00, 4'd0, 1'b0},   // no effect in step mode
        '{K_PLAIN, 8'h07,          8'h00, 4'd0, 1'b0},
        '{K_STEP,  CMD_STEP,       8'h33, 4'd1, 1'b0},
        '{K_PLAIN, CMD_REPROGRAM,  8'h00, 4'd0, 1'b0},
        '{K_LOAD,  CMD_START,      8'h00, 4'd0, 1'b1},
        '{K_PLAIN, 8'h44,          8'h00, 4'd0, 1'b0},   // unknown, back to idle
        '{K_PLAIN, CMD_CONTINUOUS, 8'h00, 4'd0, 1'b0},
        '{K_LOAD,  CMD_START,      8'h00, 4'd0, 1'b0},
        '{K_RUN,   CMD_CONTINUOUS, 8'h5A, 4'd2, 1'b0}};

    `include "tb_helpers.svh"

    debug_unit i_debug_unit (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data      (rx_data),
        .tx_done_tick (tx_done_tick),
        .halt         (halt),
        .cpu_status   (cpu_status),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .imem         (imem),
        .cpu_ctrl     (cpu_ctrl)
    );

    always #10 clk = !clk;

    // sampled mid cycle, away from both clock and stimulus
    always @(negedge clk)
    begin
        if (imem.en)
        begin
            wr_addr_q.push_back(imem.addr);
            wr_data_q.push_back(imem.data);
        end
        if (cpu_ctrl.run_en)
            run_cnt++;
        if (tx_start && !tx_start_q)
            reply_cnt++;
        tx_start_q = tx_start;
    end

    //////////////////////////////////////////////////
    // host model
    //////////////////////////////////////////////////

    task automatic answer_reply(input byte_t expected);
        wait_level(SIG_TX_START, 1'b1, "tx_start to rise");
        check_value("tx_data", tx_data, expected);
        repeat (lfsr_take(3))                      // slow uart
        begin
            @(posedge clk);
            #2;
        end
        tx_done_tick = 1'b1;
        @(posedge clk);
        #2;
        tx_done_tick = 1'b0;
        wait_level(SIG_TX_START, 1'b0, "tx_start to fall");
    endtask

    task automatic load_program(input int sel);
        wr_addr_q.delete();
        wr_data_q.delete();
        send_byte(CMD_START);
        check_value("debug_mode", cpu_ctrl.debug_mode, 1);
        for (int w = 0; w < prog_len[sel]; w++)
            for (int b = 0; b < BYTES_PER_WORD; b++)
                send_byte(prog_words[sel][w][b*BYTE_W +: BYTE_W]);   // lsb first
        wait_writes(prog_len[sel]);
        wait_level(SIG_DEBUG_MODE, 1'b0, "debug_mode to fall");
        check_value("imem.en count", wr_addr_q.size(), prog_len[sel]);
        for (int w = 0; w < prog_len[sel] && w < wr_addr_q.size(); w++)
        begin
            check_value("imem.addr", wr_addr_q[w], w);
            check_value("imem.data", wr_data_q[w], prog_words[sel][w]);
        end
    endtask

    task automatic apply_command(input cmd_entry_t entry);
        int runs_before;
        int replies_before;
        int writes_before;
        runs_before    = run_cnt;
        replies_before = reply_cnt;
        writes_before  = wr_addr_q.size();
        cpu_status     = entry.status;
        send_byte(entry.cmd);
        if (entry.kind == K_RUN)
        begin
            wait_level(SIG_RUN_EN, 1'b1, "run_en to rise");
            repeat (int'(entry.run_cycles) - 1)
            begin
                @(posedge clk);
                #2;
            end
            halt = 1'b1;                           // cpu reached its halt word
        end
        if (entry.kind != K_PLAIN)
            answer_reply(entry.status);
        halt = 1'b0;
        repeat (4)
        begin
            @(posedge clk);
            #2;
        end
        check_value("run_en cycles", run_cnt - runs_before, entry.run_cycles);
        check_value("tx_start count", reply_cnt - replies_before, entry.kind != K_PLAIN);
        check_value("imem.en count", wr_addr_q.size() - writes_before, 0);
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        rx_done_tick = 1'b0;
        rx_data      = '0;
        tx_done_tick = 1'b0;
        halt         = 1'b0;
        cpu_status   = '0;
        lfsr_state   = 16'd32942;
        errors       = 0;
        timeouts     = 0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("imem.en", imem.en, 0);
        check_value("tx_start", tx_start, 0);
        check_value("run_en", cpu_ctrl.run_en, 0);
        check_value("debug_mode", cpu_ctrl.debug_mode, 0);
        for (int i = 0; i < N_CMDS; i++)
        begin
            if (cmd_table[i].kind == K_LOAD)
                load_program(int'(cmd_table[i].prog_sel));
            else
                apply_command(cmd_table[i]);
        end
        $display("checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: debug_unit.f
+incdir+testbench
logic/debug_pkg.sv
logic/rx_byte_capture.sv
logic/instr_assembler.sv
logic/debug_controller.sv
logic/reply_sender.sv
logic/debug_unit.sv
testbench/tb_debug_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the debug unit testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f debug_unit.f --top-module tb_debug_unit -o sim_debug_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_debug_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fqx ">>> PASS"; then
    exit 0
fi
exit 1
